// ==== design/kbdPkg.sv ====
// shared types, PS/2 frame widths, scan-code constants, decoder state and host register enums
package kbdPkg;

    // byte types on the scan-code and character paths
    typedef logic [7:0] scanCodeT;
    typedef logic [7:0] asciiT;

    // one PS/2 frame is start, 8 data bits, parity and stop
    localparam int frameBits = 11;
    localparam int cntBits   = 4;  // wide enough to count to frameBits

    // prefix bytes sent by the keyboard
    localparam scanCodeT breakCode = 8'hF0;  // key release
    localparam scanCodeT extCode   = 8'hE0;  // extended key

    // the two shift keys of the US layout
    localparam scanCodeT leftShiftCode  = 8'h12;
    localparam scanCodeT rightShiftCode = 8'h59;

    // prefix tracking in the scan-code decoder
    typedef enum logic [1:0]
    {
        decNormal   = 2'd0,
        decBreak    = 2'd1,  // F0 seen
        decExt      = 2'd2,  // E0 seen
        decExtBreak = 2'd3   // E0 F0 seen
    } decStateT;

    // host register map, selected by the one-bit address
    typedef enum logic
    {
        regData   = 1'b0,
        regStatus = 1'b1
    } hostRegT;

endpackage

// ==== design/ps2Receiver.sv ====
// PS/2 line synchronizer, keyboard clock falling-edge detector and 11-bit frame collector
`timescale 1ns/10ps

module ps2Receiver
(
    input  logic             clk,
    input  logic             rst,
    input  logic             keyClk,      // clock from the keyboard
    input  logic             keyDin,      // data from the keyboard
    output kbdPkg::scanCodeT scanCode,    // bits 1 to 8 of the last frame
    output logic             frameValid   // one-cycle pulse per frame
);

    logic [1:0]                 clkSync;
    logic [1:0]                 dinSync;
    logic                       clkPrev;
    logic                       fallEdge;
    logic                       lastBit;
    logic [kbdPkg::cntBits-1:0] bitCnt;
    logic [kbdPkg::frameBits-1:0] shiftReg;
    logic [kbdPkg::frameBits-1:0] shiftNext;

    // both lines idle high, so the sync flops come out of reset at 1
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            clkSync <= 2'b11;
            dinSync <= 2'b11;
            clkPrev <= 1'b1;
        end
        else
        begin
            clkSync <= {clkSync[0], keyClk};
            dinSync <= {dinSync[0], keyDin};
            clkPrev <= clkSync[1];
        end
    end

    assign fallEdge  = clkPrev & ~clkSync[1];
    assign lastBit   = (bitCnt == kbdPkg::cntBits'(kbdPkg::frameBits - 1));
    assign shiftNext = {dinSync[1], shiftReg[kbdPkg::frameBits-1:1]};  // lsb first

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            bitCnt     <= '0;
            frameValid <= 1'b0;
        end
        else
        begin
            frameValid <= 1'b0;
            if (fallEdge)
            begin
                if (lastBit)
                begin
                    bitCnt     <= '0;
                    frameValid <= 1'b1;  // parity and stop are not checked
                end
                else
                    bitCnt <= bitCnt + 1'b1;
            end
        end
    end

    // frame payload
    always_ff @(posedge clk)
    begin
        if (fallEdge)
        begin
            shiftReg <= shiftNext;
            if (lastBit)
                scanCode <= shiftNext[8:1];
        end
    end

endmodule

// ==== design/scanDecoder.sv ====
// scan-code prefix FSM, shift key tracking and character-ready pulse
`timescale 1ns/10ps

module scanDecoder
(
    input  logic             clk,
    input  logic             rst,
    input  kbdPkg::scanCodeT scanCode,
    input  logic             frameValid,
    output kbdPkg::scanCodeT mapCode,       // to the key map
    output logic             mapShift,
    input  kbdPkg::asciiT    mapAscii,      // from the key map
    input  logic             mapSupported,
    output logic             charValid,     // one-cycle pulse per character
    output kbdPkg::asciiT    charCode
);

    kbdPkg::decStateT state;
    kbdPkg::decStateT stateNext;
    logic             shift;
    logic             shiftNext;
    logic             isShift;
    logic             charFire;

    // the map looks at the byte of the current frame
    assign mapCode  = scanCode;
    assign mapShift = shift;

    assign isShift = (scanCode == kbdPkg::leftShiftCode) ||
                     (scanCode == kbdPkg::rightShiftCode);

    always_comb
    begin
        stateNext = state;
        shiftNext = shift;
        charFire  = 1'b0;
        if (frameValid)
        begin
            case (state)
                kbdPkg::decNormal:
                begin
                    if (scanCode == kbdPkg::breakCode)
                        stateNext = kbdPkg::decBreak;
                    else if (scanCode == kbdPkg::extCode)
                        stateNext = kbdPkg::decExt;
                    else if (isShift)
                        shiftNext = 1'b1;
                    else
                        charFire = mapSupported;  // unknown keys are dropped
                end
                kbdPkg::decBreak:
                begin
                    // released key, only shift matters
                    if (isShift)
                        shiftNext = 1'b0;
                    stateNext = kbdPkg::decNormal;
                end
                kbdPkg::decExt:
                begin
                    if (scanCode == kbdPkg::breakCode)
                        stateNext = kbdPkg::decExtBreak;
                    else
                        stateNext = kbdPkg::decNormal;  // extended make is ignored
                end
                kbdPkg::decExtBreak:
                    stateNext = kbdPkg::decNormal;
                default:
                    stateNext = kbdPkg::decNormal;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= kbdPkg::decNormal;
            shift     <= 1'b0;
            charValid <= 1'b0;
        end
        else
        begin
            state     <= stateNext;
            shift     <= shiftNext;
            charValid <= charFire;
        end
    end

    // character payload
    always_ff @(posedge clk)
    begin
        if (charFire)
            charCode <= mapAscii;
    end

endmodule

// ==== design/keyMap.sv ====
// US layout scan code to ASCII table with shifted symbols and supported flag
`timescale 1ns/10ps

module keyMap
(
    input  kbdPkg::scanCodeT code,
    input  logic             shift,
    output kbdPkg::asciiT    ascii,
    output logic             supported
);

    always_comb
    begin
        supported = 1'b1;
        case (code)
            // letters are upper case in both shift states
            8'h1C: ascii = "A";
            8'h32: ascii = "B";
            8'h21: ascii = "C";
            8'h23: ascii = "D";
            8'h24: ascii = "E";
            8'h2B: ascii = "F";
            8'h34: ascii = "G";
            8'h33: ascii = "H";
            8'h43: ascii = "I";
            8'h3B: ascii = "J";
            8'h42: ascii = "K";
            8'h4B: ascii = "L";
            8'h3A: ascii = "M";
            8'h31: ascii = "N";
            8'h44: ascii = "O";
            8'h4D: ascii = "P";
            8'h15: ascii = "Q";
            8'h2D: ascii = "R";
            8'h1B: ascii = "S";
            8'h2C: ascii = "T";
            8'h3C: ascii = "U";
            8'h2A: ascii = "V";
            8'h1D: ascii = "W";
            8'h22: ascii = "X";
            8'h35: ascii = "Y";
            8'h1A: ascii = "Z";

            // digit row
            8'h45: ascii = shift ? ")" : "0";
            8'h16: ascii = shift ? "!" : "1";
            8'h1E: ascii = shift ? "@" : "2";
            8'h26: ascii = shift ? "#" : "3";
            8'h25: ascii = shift ? "$" : "4";
            8'h2E: ascii = shift ? "%" : "5";
            8'h36: ascii = shift ? "^" : "6";
            8'h3D: ascii = shift ? "&" : "7";
            8'h3E: ascii = shift ? "*" : "8";
            8'h46: ascii = shift ? "(" : "9";

            8'h4E: ascii = shift ? "_" : "-";
            8'h55: ascii = shift ? "+" : "=";
            8'h5D: ascii = shift ? "|" : 8'h5C;  // backslash
            8'h66: ascii = 8'd8;                  // backspace
            8'h29: ascii = " ";
            8'h5A: ascii = 8'd13;                 // enter

            // punctuation
            8'h54: ascii = shift ? "{" : "[";
            8'h5B: ascii = shift ? "}" : "]";
            8'h4C: ascii = shift ? ":" : ";";
            8'h52: ascii = shift ? "\"" : "'";
            8'h41: ascii = shift ? "<" : ",";
            8'h49: ascii = shift ? ">" : ".";
            8'h4A: ascii = shift ? "?" : "/";

            default:
            begin
                // function keys, keypad and the rest
                ascii     = 8'h00;
                supported = 1'b0;
            end
        endcase
    end

endmodule

// ==== design/hostPort.sv ====
// character buffer, ready flag and registered host read bus
`timescale 1ns/10ps

module hostPort
(
    input  logic            clk,
    input  logic            rst,
    input  logic            charValid,
    input  kbdPkg::asciiT   charCode,
    input  logic            cs,          // every cycle with cs high is a read
    input  kbdPkg::hostRegT address,
    output logic [7:0]      dout
);

    kbdPkg::asciiT charBuf;
    logic          ready;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ready <= 1'b0;
            dout  <= 8'h00;
        end
        else
        begin
            // a new character beats a data read in the same cycle
            if (charValid)
                ready <= 1'b1;
            else if (cs && (address == kbdPkg::regData))
                ready <= 1'b0;

            if (cs)
            begin
                if (address == kbdPkg::regData)
                    dout <= {1'b0, charBuf[6:0]};
                else
                    dout <= {ready, 7'b0};  // status
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (charValid)
            charBuf <= charCode;  // overwrites an unread character
    end

endmodule

// ==== design/ps2Keyboard.sv ====
// PS/2 keyboard top level with receiver, decoder, key map and host port
`timescale 1ns/10ps

module ps2Keyboard
(
    input  logic            clk,
    input  logic            rst,
    input  logic            keyClk,
    input  logic            keyDin,
    input  logic            cs,
    input  kbdPkg::hostRegT address,
    output logic [7:0]      dout
);

    kbdPkg::scanCodeT scanCode;
    logic             frameValid;
    kbdPkg::scanCodeT mapCode;
    logic             mapShift;
    kbdPkg::asciiT    mapAscii;
    logic             mapSupported;
    logic             charValid;
    kbdPkg::asciiT    charCode;

    ps2Receiver receiver_i
    (
        .clk        (clk),
        .rst        (rst),
        .keyClk     (keyClk),
        .keyDin     (keyDin),
        .scanCode   (scanCode),
        .frameValid (frameValid)
    );

    scanDecoder decoder_i
    (
        .clk          (clk),
        .rst          (rst),
        .scanCode     (scanCode),
        .frameValid   (frameValid),
        .mapCode      (mapCode),
        .mapShift     (mapShift),
        .mapAscii     (mapAscii),
        .mapSupported (mapSupported),
        .charValid    (charValid),
        .charCode     (charCode)
    );

    // combinational lookup, answers in the same cycle
    keyMap keyMap_i
    (
        .code      (mapCode),
        .shift     (mapShift),
        .ascii     (mapAscii),
        .supported (mapSupported)
    );

    hostPort hostPort_i
    (
        .clk       (clk),
        .rst       (rst),
        .charValid (charValid),
        .charCode  (charCode),
        .cs        (cs),
        .address   (address),
        .dout      (dout)
    );

endmodule

// ==== tb/ps2Keyboard_props.sv ====
// concurrent assertions on the frame and character pulses and on dout after reset
`timescale 1ns/10ps

module ps2KeyboardProps
(
    input logic             clk,
    input logic             rst,
    input logic             frameValid,
    input logic             charValid,
    input kbdPkg::decStateT decState,
    input logic [7:0]       dout
);

    // one pulse per frame
    framePulse: assert property (@(posedge clk) disable iff (rst) frameValid |=> !frameValid)
        else $error("frameValid high for two cycles in a row");

    charAfterFrame: assert property (@(posedge clk) disable iff (rst)
        charValid |-> $past(frameValid) && ($past(decState) == kbdPkg::decNormal))
        else $error("charValid without a frame seen in decNormal");

    doutAfterReset: assert property (@(posedge clk) $fell(rst) |-> (dout == 8'h00))
        else $error("dout not zero after reset release");

endmodule

bind ps2Keyboard ps2KeyboardProps props_i
(
    .clk        (clk),
    .rst        (rst),
    .frameValid (frameValid),
    .charValid  (charValid),
    .decState   (decoder_i.state),
    .dout       (dout)
);

// ==== tb/tbPs2Keyboard.sv ====
// testbench for the PS/2 keyboard with frame driver, LFSR, reference key map, host reads and checks
`timescale 1ns/10ps

module tbPs2Keyboard;

    localparam int tableSize   = 49;
    localparam int readyPolls  = 40;      // status reads before giving up on ready
    localparam int idleCycles  = 30;      // well above the frame-to-ready latency
    localparam int watchdogCyc = 100000;

    // letters A to Z, digits 0 to 9, then - = \ backspace space enter [ ] ; ' , . /
    localparam logic [8*tableSize-1:0] codeTab =
    {
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
        8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
        8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A, 8'h45, 8'h16, 8'h1E, 8'h26,
        8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46, 8'h4E, 8'h55, 8'h5D, 8'h66,
        8'h29, 8'h5A, 8'h54, 8'h5B, 8'h4C, 8'h52, 8'h41, 8'h49, 8'h4A
    };
    localparam logic [8*tableSize-1:0] plainTab =
        {"ABCDEFGHIJKLMNOPQRSTUVWXYZ0123456789-=\\", 8'h08, " ", 8'h0D, "[];',./"};
    localparam logic [8*tableSize-1:0] shiftTab =
        {"ABCDEFGHIJKLMNOPQRSTUVWXYZ)!@#$%^&*(_+|", 8'h08, " ", 8'h0D, "{}:\"<>?"};

    logic            clk        = 1'b0;
    logic            rst        = 1'b1;
    logic            keyClk     = 1'b1;   // PS/2 lines idle high
    logic            keyDin     = 1'b1;
    logic            cs         = 1'b0;
    kbdPkg::hostRegT address    = kbdPkg::regData;
    logic [7:0]      dout;
    logic            dataRdSeen = 1'b0;
    logic [31:0]     lfsrState  = 32'h213a_48d3;
    logic [7:0]      expQ[$];             // characters expected from data reads
    int              errCount   = 0;
    int              checkCount = 0;
    int              testCount  = 0;
    int              testErrs   = 0;
    string           testName;

    ps2Keyboard dut_i
    (
        .clk     (clk),
        .rst     (rst),
        .keyClk  (keyClk),
        .keyDin  (keyDin),
        .cs      (cs),
        .address (address),
        .dout    (dout)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    task automatic randBits(input int n, output int val);
        int i;
        val = 0;
        for (i = 0; i < n; i++)
        begin
            lfsrState = lfsrNext(lfsrState);
            val = (val << 1) | int'(lfsrState[0]);
        end
    endtask

    function automatic logic [7:0] codeAt(input int idx);
        return codeTab[8*(tableSize-1-idx) +: 8];
    endfunction

    // expected {supported, character} for a make code
    function automatic logic [8:0] refMap(input logic [7:0] code, input logic shift);
        int         i;
        logic [8:0] res;
        res = 9'h000;
        for (i = 0; i < tableSize; i++)
        begin
            if (codeAt(i) == code)
                res = {1'b1, shift ? shiftTab[8*(tableSize-1-i) +: 8]
                                   : plainTab[8*(tableSize-1-i) +: 8]};
        end
        return res;
    endfunction

    task automatic pickCode(input int first, input int count, output logic [7:0] code);
        int v;
        randBits(8, v);
        code = codeAt(first + v % count);
    endtask

    task automatic checkEq(input string name, input logic [7:0] got, input logic [7:0] exp);
        checkCount++;
        if (got !== exp)
        begin
            errCount++;
            $display("FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // start, data lsb first, odd parity, stop
    task automatic sendFrame(input logic [7:0] code);
        logic [10:0] frame;
        int          i;
        frame = {1'b1, ~^code, code, 1'b0};
        for (i = 0; i < 11; i++)
        begin
            @(posedge clk);
            keyDin <= frame[i];           // data moves while keyClk is high
            repeat (3) @(posedge clk);
            keyClk <= 1'b0;
            repeat (6) @(posedge clk);
            keyClk <= 1'b1;
            repeat (2) @(posedge clk);
        end
        @(posedge clk);
        keyDin <= 1'b1;
        repeat (10) @(posedge clk);
    endtask

    task automatic hostRead(input kbdPkg::hostRegT a, output logic [7:0] val);
        @(posedge clk);
        cs      <= 1'b1;
        address <= a;
        @(posedge clk);
        cs <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        val = dout;
    endtask

    task automatic waitReady();
        logic [7:0] st;
        logic       seen;
        int         n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < readyPolls)
        begin
            hostRead(kbdPkg::regStatus, st);
            seen = st[7];
            n++;
        end
        if (!seen)
        begin
            errCount++;
            $display("ready did not come up within %0d status reads at %0t", readyPolls, $time);
        end
        else
            checkEq("status", st, 8'h80);
    endtask

    // make, release, then read the character back
    task automatic typeKey(input logic [7:0] code, input logic shift);
        logic [8:0] refVal;
        logic [7:0] st;
        refVal = refMap(code, shift);
        sendFrame(code);
        sendFrame(kbdPkg::breakCode);
        sendFrame(code);
        waitReady();
        expQ.push_back({1'b0, refVal[6:0]});
        hostRead(kbdPkg::regData, st);
        hostRead(kbdPkg::regStatus, st);
        checkEq("status", st, 8'h00);
    endtask

    task automatic expectIdle();
        logic [7:0] st;
        repeat (idleCycles) @(posedge clk);
        hostRead(kbdPkg::regStatus, st);
        checkEq("status", st, 8'h00);
    endtask

    task automatic beginTest(input string name);
        testName = name;
        testErrs = errCount;
        testCount++;
    endtask

    task automatic endTest();
        if (errCount == testErrs)
            $display("test %0d %s: ok", testCount, testName);
        else
            $display("test %0d %s: %0d errors", testCount, testName, errCount - testErrs);
    endtask

    // compares every data read against the queue of expected characters
    always @(posedge clk)
        dataRdSeen <= cs && (address == kbdPkg::regData);

    always @(negedge clk)
    begin
        if (dataRdSeen)
        begin
            if (expQ.size() == 0)
            begin
                errCount++;
                $display("data read with no character expected at %0t", $time);
            end
            else
                checkEq("dout", dout, expQ.pop_front());
        end
    end

    initial
    begin
        repeat (watchdogCyc) @(posedge clk);
        $display("simulation did not finish within %0d cycles", watchdogCyc);
        $display("sim failed");
        $finish;
    end

    initial
    begin
        logic [7:0] code;
        logic [7:0] code2;
        logic [7:0] shiftCode;
        logic [7:0] st;
        logic [8:0] ref2;
        int         v;
        int         k;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        beginTest("unshifted keys");
        for (k = 0; k < 20; k++)
        begin
            pickCode(0, tableSize, code);
            typeKey(code, 1'b0);
        end
        endTest();

        beginTest("shifted keys");
        randBits(1, v);
        shiftCode = v[0] ? kbdPkg::rightShiftCode : kbdPkg::leftShiftCode;
        sendFrame(shiftCode);
        for (k = 0; k < 6; k++)
        begin
            pickCode(26, 23, code);       // digits and symbols
            typeKey(code, 1'b1);
        end
        sendFrame(kbdPkg::breakCode);
        sendFrame(shiftCode);
        for (k = 0; k < 4; k++)
        begin
            pickCode(26, 23, code);
            typeKey(code, 1'b0);
        end
        endTest();

        beginTest("release prefix");
        for (k = 0; k < 4; k++)
        begin
            pickCode(0, tableSize, code);
            sendFrame(kbdPkg::breakCode);
            sendFrame(code);
            expectIdle();
        end
        endTest();

        beginTest("extended prefix");
        pickCode(0, 26, code);
        sendFrame(kbdPkg::extCode);
        sendFrame(code);
        expectIdle();
        sendFrame(kbdPkg::extCode);
        sendFrame(kbdPkg::breakCode);
        sendFrame(code);
        expectIdle();
        pickCode(0, tableSize, code);
        typeKey(code, 1'b0);
        endTest();

        beginTest("unsupported codes");
        sendFrame(8'h05);
        expectIdle();
        sendFrame(8'h76);
        expectIdle();
        endTest();

        beginTest("overwrite");
        pickCode(0, 26, code);
        pickCode(0, 25, code2);
        if (code2 == code)
            code2 = codeAt(25);           // keep the two letters apart
        sendFrame(code);
        sendFrame(kbdPkg::breakCode);
        sendFrame(code);
        sendFrame(code2);
        sendFrame(kbdPkg::breakCode);
        sendFrame(code2);
        waitReady();
        ref2 = refMap(code2, 1'b0);
        expQ.push_back({1'b0, ref2[6:0]});  // second character only
        hostRead(kbdPkg::regData, st);
        hostRead(kbdPkg::regStatus, st);
        checkEq("status", st, 8'h00);
        endTest();

        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
        if (errCount == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== tb.f ====
design/kbdPkg.sv
design/ps2Receiver.sv
design/scanDecoder.sv
design/keyMap.sv
design/hostPort.sv
design/ps2Keyboard.sv
tb/ps2Keyboard_props.sv
tb/tbPs2Keyboard.sv

// ==== run.sh ====
#!/bin/sh
# build and run the PS/2 keyboard testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f tb.f --top-module tbPs2Keyboard -o simTb

out=$(./obj_dir/simTb)
echo "$out"
echo "$out" | grep -qx "sim passed"
